/* filelist.f */
+incdir+test
logic/fp_format_pkg.sv
logic/fpu_ctrl_pkg.sv
logic/operand_unpack.sv
logic/float_multiplier.sv
logic/mul_round_pack.sv
logic/fpu_mul_top.sv
test/fpu_mul_tb.sv

/* logic/float_multiplier.sv */
`timescale 1ns/1ps

module float_multiplier
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input	logic					clk,
	input	logic					reset,
	input	logic					flush,

	input	logic					valid_in,
	output	logic					ready_out,
	output	logic					valid_out,
	input	logic					ready_in,

	input	fpu_op_t				op,
	input	fpu_rm_t				rm,

	input	logic	[FP_MAN_W-1:0]	man_a,
	input	logic	[FP_EXP_W-1:0]	exp_a,
	input	logic					sgn_a,
	input	logic					zero_a,
	input	logic					inf_a,
	input	logic					sNaN_a,
	input	logic					qNaN_a,

	input	logic	[FP_MAN_W-1:0]	man_b,
	input	logic	[FP_EXP_W-1:0]	exp_b,
	input	logic					sgn_b,
	input	logic					zero_b,
	input	logic					inf_b,
	input	logic					sNaN_b,
	input	logic					qNaN_b,

	output	logic	[FP_MAN_W-1:0]	man_y,
	output	logic	[FP_EXP_W-1:0]	exp_y,
	output	logic					sgn_y,

	output	logic					round_bit,
	output	logic					sticky_bit,
	output	logic					skip_round,

	output	logic					IV,

	output	fpu_rm_t				rm_out
);

	typedef enum logic [1:0] {IDLE, LOAD, CALC} state_t;

	state_t						state;
	fp_unpacked_t				a_buf;
	fp_unpacked_t				b_buf;
	logic	[2*FP_MAN_W-1:0]	res_buf;
	logic	[FP_EXP_W-1:0]		exp_y_buf;
	logic						sgn_y_buf;
	logic	[1:0]				counter;
	logic	[FP_MAN_W+5:0]		acc;

	logic						valid_in_int;
	logic						load;
	logic						is_nan;
	logic						is_inf;
	logic						is_zero;
	logic						special;

	// Other opcodes are still taken from the bus, then dropped.
	assign valid_in_int = valid_in && (op == FPU_OP_MUL);
	assign ready_out = ready_in && (state == IDLE);
	assign load = valid_in_int && ready_out;

	assign is_nan = a_buf.snan || b_buf.snan || a_buf.qnan || b_buf.qnan ||
		(a_buf.zero && b_buf.inf) || (a_buf.inf && b_buf.zero);
	assign is_inf = a_buf.inf || b_buf.inf;
	assign is_zero = a_buf.zero || b_buf.zero;
	assign special = is_nan || is_inf || is_zero;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			counter <= 2'd0;
			valid_out <= 1'b0;
		end else if (flush) begin
			state <= IDLE;
			counter <= 2'd0;
			valid_out <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (ready_in)
						valid_out <= 1'b0;	// Result taken.
					if (load)
						state <= LOAD;
				end
				LOAD: begin
					counter <= 2'd0;
					if (special) begin
						valid_out <= 1'b1;
						state <= IDLE;
					end else begin
						state <= CALC;
					end
				end
				CALC: begin
					counter <= counter + 2'd1;
					if (counter == 2'd3) begin
						valid_out <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (load) begin
					a_buf <= '{man_a, exp_a, sgn_a, zero_a, inf_a, sNaN_a, qNaN_a};
					b_buf <= '{man_b, exp_b, sgn_b, zero_b, inf_b, sNaN_b, qNaN_b};
					rm_out <= rm;
				end
			end
			LOAD: begin
				sgn_y_buf <= a_buf.sgn ^ b_buf.sgn;
				skip_round <= special;
				IV <= is_nan && !(a_buf.qnan || b_buf.qnan);
				if (is_nan) begin
					res_buf <= {24'hc00000, 24'h000000};	// Canonical quiet NaN.
					exp_y_buf <= 10'h0ff;
					sgn_y_buf <= 1'b0;
				end else if (is_inf) begin
					res_buf <= {24'h800000, 24'h000000};
					exp_y_buf <= 10'h0ff;
				end else if (is_zero) begin
					res_buf <= '0;
					exp_y_buf <= '0;
				end else begin
					res_buf <= {{FP_MAN_W{1'b0}}, a_buf.man};	// Multiplier in low half.
					exp_y_buf <= a_buf.exp + b_buf.exp;
				end
			end
			CALC: res_buf <= {acc, res_buf[23:6]};
			default: res_buf <= res_buf;
		endcase
	end

	// Six multiplier bits per clock.
	always_comb begin
		acc = {6'd0, res_buf[47:24]};
		for (int i = 0; i < 6; i++) begin
			if (res_buf[i])
				acc = acc + ({6'd0, b_buf.man} << i);
		end
	end

	always_comb begin
		sgn_y = sgn_y_buf;
		if (res_buf[47] || skip_round) begin
			exp_y = exp_y_buf + FP_EXP_W'(!skip_round);	// Product reached 2.0.
			man_y = res_buf[47:24];
			round_bit = res_buf[23];
			sticky_bit = |res_buf[22:0];
		end else begin
			exp_y = exp_y_buf;
			man_y = res_buf[46:23];
			round_bit = res_buf[22];
			sticky_bit = |res_buf[21:0];
		end
	end

endmodule

/* logic/fp_format_pkg.sv */
package fp_format_pkg;

	localparam int FP_EXP_BIAS = 127;
	localparam int FP_MAN_W = 24;          // Hidden bit included.
	localparam int FP_EXP_W = 10;          // Signed, holds a sum of two exponents.
	localparam int FP_FRAC_W = FP_MAN_W - 1;
	localparam int FP_BEXP_W = 8;          // Biased exponent field.

	// binary32 word as stored.
	typedef struct packed {
		logic                 sgn;
		logic [FP_BEXP_W-1:0] exp;
		logic [FP_FRAC_W-1:0] frac;
	} fp_word_t;

	// Decoded operand.
	typedef struct packed {
		logic [FP_MAN_W-1:0] man;
		logic [FP_EXP_W-1:0] exp;          // Unbiased.
		logic                sgn;
		logic                zero;         // Subnormals land here too.
		logic                inf;
		logic                snan;
		logic                qnan;
	} fp_unpacked_t;

endpackage

/* logic/fpu_ctrl_pkg.sv */
package fpu_ctrl_pkg;

	// Shared with the other units of the FPU.
	typedef enum logic [4:0] {
		FPU_OP_ADD  = 5'd0,
		FPU_OP_SUB  = 5'd1,
		FPU_OP_MUL  = 5'd2,
		FPU_OP_DIV  = 5'd3,
		FPU_OP_SQRT = 5'd4,
		FPU_OP_MIN  = 5'd5,
		FPU_OP_MAX  = 5'd6,
		FPU_OP_CMP  = 5'd7
	} fpu_op_t;

	typedef enum logic [2:0] {
		RM_RNE = 3'b000,
		RM_RTZ = 3'b001,
		RM_RDN = 3'b010,
		RM_RUP = 3'b011,
		RM_RMM = 3'b100
	} fpu_rm_t;

	typedef struct packed {
		logic nv;
		logic dz;                          // Never set by the multiply path.
		logic of;
		logic uf;
		logic nx;
	} fpu_flags_t;

endpackage

/* logic/fpu_mul_top.sv */
`timescale 1ns/1ps

module fpu_mul_top
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input	logic		clk,
	input	logic		reset,
	input	logic		flush,

	input	logic		valid_in,
	output	logic		ready_out,
	output	logic		valid_out,
	input	logic		ready_in,

	input	fp_word_t	a_word,
	input	fp_word_t	b_word,
	input	fpu_op_t	op,
	input	fpu_rm_t	rm,

	output	fp_word_t	y_word,
	output	fpu_flags_t	flags
);

	fp_unpacked_t			a_u;
	fp_unpacked_t			b_u;
	fpu_op_t				op_u;
	fpu_rm_t				rm_u;
	fpu_rm_t				rm_m;
	logic					valid_u;
	logic					ready_m;
	logic					valid_m;
	logic					ready_r;
	logic	[FP_MAN_W-1:0]	man_m;
	logic	[FP_EXP_W-1:0]	exp_m;
	logic					sgn_m;
	logic					round_m;
	logic					sticky_m;
	logic					skip_m;
	logic					iv_m;

	operand_unpack operand_unpack_i (
		.clk		(clk),
		.reset		(reset),
		.flush		(flush),
		.valid_in	(valid_in),
		.ready_out	(ready_out),
		.valid_out	(valid_u),
		.ready_in	(ready_m),
		.a_word		(a_word),
		.b_word		(b_word),
		.op			(op),
		.rm			(rm),
		.a			(a_u),
		.b			(b_u),
		.op_out		(op_u),
		.rm_out		(rm_u)
	);

	float_multiplier float_multiplier_i (
		.clk		(clk),
		.reset		(reset),
		.flush		(flush),
		.valid_in	(valid_u),
		.ready_out	(ready_m),
		.valid_out	(valid_m),
		.ready_in	(ready_r),
		.op			(op_u),
		.rm			(rm_u),
		.man_a		(a_u.man),
		.exp_a		(a_u.exp),
		.sgn_a		(a_u.sgn),
		.zero_a		(a_u.zero),
		.inf_a		(a_u.inf),
		.sNaN_a		(a_u.snan),
		.qNaN_a		(a_u.qnan),
		.man_b		(b_u.man),
		.exp_b		(b_u.exp),
		.sgn_b		(b_u.sgn),
		.zero_b		(b_u.zero),
		.inf_b		(b_u.inf),
		.sNaN_b		(b_u.snan),
		.qNaN_b		(b_u.qnan),
		.man_y		(man_m),
		.exp_y		(exp_m),
		.sgn_y		(sgn_m),
		.round_bit	(round_m),
		.sticky_bit	(sticky_m),
		.skip_round	(skip_m),
		.IV			(iv_m),
		.rm_out		(rm_m)
	);

	mul_round_pack mul_round_pack_i (
		.clk		(clk),
		.reset		(reset),
		.flush		(flush),
		.valid_in	(valid_m),
		.ready_out	(ready_r),
		.valid_out	(valid_out),
		.ready_in	(ready_in),
		.man		(man_m),
		.exp		(exp_m),
		.sgn		(sgn_m),
		.round_bit	(round_m),
		.sticky_bit	(sticky_m),
		.skip_round	(skip_m),
		.iv			(iv_m),
		.rm			(rm_m),
		.y_word		(y_word),
		.flags		(flags)
	);

endmodule

/* logic/mul_round_pack.sv */
`timescale 1ns/1ps

module mul_round_pack
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input	logic					clk,
	input	logic					reset,
	input	logic					flush,

	input	logic					valid_in,
	output	logic					ready_out,
	output	logic					valid_out,
	input	logic					ready_in,

	input	logic	[FP_MAN_W-1:0]	man,
	input	logic	[FP_EXP_W-1:0]	exp,
	input	logic					sgn,
	input	logic					round_bit,
	input	logic					sticky_bit,
	input	logic					skip_round,
	input	logic					iv,
	input	fpu_rm_t				rm,

	output	fp_word_t				y_word,
	output	fpu_flags_t				flags
);

	logic					accept;
	logic					inexact;
	logic					inc;
	logic					carry;
	logic					to_zero;
	logic	[FP_MAN_W:0]	man_r;
	logic	[FP_EXP_W-1:0]	exp_r;
	fp_word_t				y_d;
	fpu_flags_t				flags_d;

	assign accept = valid_in && ready_out;
	assign ready_out = !valid_out || ready_in;

	always_comb begin
		inexact = round_bit || sticky_bit;
		case (rm)
			RM_RNE: inc = round_bit && (sticky_bit || man[0]);
			RM_RDN: inc = inexact && sgn;
			RM_RUP: inc = inexact && !sgn;
			RM_RMM: inc = round_bit;
			default: inc = 1'b0;
		endcase
		man_r = {1'b0, man} + (FP_MAN_W + 1)'(inc);
		carry = man_r[FP_MAN_W];
		exp_r = exp + FP_EXP_W'(carry) + FP_EXP_W'(FP_EXP_BIAS);
		// Overflow saturates to the largest finite value in these cases.
		to_zero = (rm == RM_RTZ) || (rm == RM_RDN && !sgn) || (rm == RM_RUP && sgn);

		flags_d = '0;
		flags_d.nx = inexact;
		y_d.sgn = sgn;
		y_d.exp = exp_r[FP_BEXP_W-1:0];
		y_d.frac = man_r[FP_FRAC_W-1:0];

		if (skip_round) begin
			y_d.exp = exp[FP_BEXP_W-1:0];	// Already biased.
			y_d.frac = man[FP_FRAC_W-1:0];
			flags_d = '0;
			flags_d.nv = iv;
		end else if ($signed(exp_r) >= 255) begin
			y_d.exp = to_zero ? 8'hfe : 8'hff;
			y_d.frac = to_zero ? '1 : '0;
			flags_d.of = 1'b1;
			flags_d.nx = 1'b1;
		end else if ($signed(exp_r) <= 0) begin
			y_d.exp = '0;	// Flush to signed zero.
			y_d.frac = '0;
			flags_d.uf = 1'b1;
			flags_d.nx = 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (flush) begin
			valid_out <= 1'b0;
		end else if (accept) begin
			valid_out <= 1'b1;
		end else if (ready_in) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			y_word <= y_d;
			flags <= flags_d;
		end
	end

endmodule

/* logic/operand_unpack.sv */
`timescale 1ns/1ps

module operand_unpack
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
(
	input	logic			clk,
	input	logic			reset,
	input	logic			flush,

	input	logic			valid_in,
	output	logic			ready_out,
	output	logic			valid_out,
	input	logic			ready_in,

	input	fp_word_t		a_word,
	input	fp_word_t		b_word,
	input	fpu_op_t		op,
	input	fpu_rm_t		rm,

	output	fp_unpacked_t	a,
	output	fp_unpacked_t	b,
	output	fpu_op_t		op_out,
	output	fpu_rm_t		rm_out
);

	logic	accept;

	function automatic fp_unpacked_t unpack(input fp_word_t w);
		fp_unpacked_t	u;
		logic			exp_max;
		exp_max = &w.exp;
		u.man = {w.exp != '0, w.frac};
		u.exp = FP_EXP_W'(w.exp) - FP_EXP_W'(FP_EXP_BIAS);
		u.sgn = w.sgn;
		u.zero = (w.exp == '0);
		u.inf = exp_max && (w.frac == '0);
		u.snan = exp_max && (w.frac != '0) && !w.frac[FP_FRAC_W-1];
		u.qnan = exp_max && w.frac[FP_FRAC_W-1];
		return u;
	endfunction

	assign accept = valid_in && ready_out;
	assign ready_out = !valid_out || ready_in;	// Empty, or drains this clock.

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (flush) begin
			valid_out <= 1'b0;
		end else if (accept) begin
			valid_out <= 1'b1;
		end else if (ready_in) begin
			valid_out <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			a <= unpack(a_word);
			b <= unpack(b_word);
			op_out <= op;
			rm_out <= rm;
		end
	end

endmodule

/* test/fpu_mul_model.svh */
`ifndef FPU_MUL_MODEL_SVH
`define FPU_MUL_MODEL_SVH

// Subnormal inputs read as zero, every NaN result is the canonical quiet NaN.
task automatic expected_product(input fp_word_t a, input fp_word_t b, input fpu_rm_t rm,
		output fp_word_t y, output fpu_flags_t f);
	logic			sgn;
	logic			a_nan;
	logic			b_nan;
	logic			a_inf;
	logic			b_inf;
	logic			a_zero;
	logic			b_zero;
	logic			rnd;
	logic			stk;
	logic			up;
	logic	[47:0]	p;
	logic	[24:0]	m;
	int				e;
	f = '0;
	sgn = a.sgn ^ b.sgn;
	a_nan = (&a.exp) && (a.frac != '0);
	b_nan = (&b.exp) && (b.frac != '0);
	a_inf = (&a.exp) && (a.frac == '0);
	b_inf = (&b.exp) && (b.frac == '0);
	a_zero = (a.exp == '0);
	b_zero = (b.exp == '0);
	if (a_nan || b_nan || (a_zero && b_inf) || (a_inf && b_zero)) begin
		y = 32'h7fc0_0000;
		f.nv = !((a_nan && a.frac[22]) || (b_nan && b.frac[22]));
	end else if (a_inf || b_inf) begin
		y = {sgn, 8'hff, 23'd0};
	end else if (a_zero || b_zero) begin
		y = {sgn, 31'd0};
	end else begin
		p = 48'({1'b1, a.frac}) * 48'({1'b1, b.frac});
		e = int'(a.exp) + int'(b.exp) - FP_EXP_BIAS + int'(p[47]);
		if (!p[47])
			p = p << 1;			// Leading one to the top.
		m = {1'b0, p[47:24]};
		rnd = p[23];
		stk = |p[22:0];
		case (rm)
			RM_RNE: up = rnd && (stk || m[0]);
			RM_RMM: up = rnd;
			RM_RUP: up = (rnd || stk) && !sgn;
			RM_RDN: up = (rnd || stk) && sgn;
			default: up = 1'b0;
		endcase
		m = m + 25'(up);
		if (m[24]) begin
			m = m >> 1;
			e = e + 1;
		end
		f.nx = rnd || stk;
		if (e >= 255) begin
			f.of = 1'b1;
			f.nx = 1'b1;
			if (rm == RM_RTZ || (rm == RM_RDN && !sgn) || (rm == RM_RUP && sgn))
				y = {sgn, 8'hfe, 23'h7f_ffff};
			else
				y = {sgn, 8'hff, 23'd0};
		end else if (e <= 0) begin
			y = {sgn, 31'd0};
			f.uf = 1'b1;
			f.nx = 1'b1;
		end else begin
			y = {sgn, 8'(e), m[22:0]};
		end
	end
endtask

`endif

/* test/fpu_mul_tb.sv */
`timescale 1ns/1ps

module fpu_mul_tb
	import fp_format_pkg::*, fpu_ctrl_pkg::*;
();

	`include "fpu_mul_model.svh"

	typedef struct packed {
		fp_word_t		y;
		fpu_flags_t		f;
		logic	[31:0]	cyc;		// Acceptance edge.
		logic	[3:0]	lat;		// Zero when latency is free.
	} expect_t;

	localparam int N_NORMAL = 5 * 9;
	localparam int N_SPECIAL = 12;
	localparam int N_RANGE = 15;
	localparam int N_STREAM = 30;
	localparam int N_FLUSH = 4;
	localparam int N_OTHER = 4;
	localparam int CYCLE_LIMIT =
		12 * (N_NORMAL + N_SPECIAL + N_RANGE + N_STREAM + N_FLUSH + N_OTHER) + 200;

	logic		clk = 1'b0;
	logic		reset;
	logic		flush;
	logic		valid_in;
	logic		ready_out;
	logic		valid_out;
	logic		ready_in;
	fp_word_t	a_word;
	fp_word_t	b_word;
	fpu_op_t	op;
	fpu_rm_t	rm;
	fp_word_t	y_word;
	fpu_flags_t	flags;

	integer		seed = 32'h0e8c_6623;
	int			cycle = 0;
	int			errors = 0;
	int			checks = 0;
	int			tests = 0;
	logic		stall_on = 1'b0;
	logic		held = 1'b0;
	fp_word_t	held_y;
	fpu_flags_t	held_f;
	expect_t	exp_q[$];

	fpu_mul_top fpu_mul_top_i (
		.clk		(clk),
		.reset		(reset),
		.flush		(flush),
		.valid_in	(valid_in),
		.ready_out	(ready_out),
		.valid_out	(valid_out),
		.ready_in	(ready_in),
		.a_word		(a_word),
		.b_word		(b_word),
		.op			(op),
		.rm			(rm),
		.y_word		(y_word),
		.flags		(flags)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles with %0d results pending", cycle, exp_q.size());
			$display("Result: FAILED");
			$finish;
		end
	end

	always @(posedge clk)
		if (stall_on)
			ready_in <= ($random(seed) & 32'd1) != 0;

	task automatic report_mismatch(input string sig, input logic [31:0] expv,
			input logic [31:0] actv);
		$display("MISMATCH t=%0t %s expected %h actual %h", $time, sig, expv, actv);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
	endtask

	always @(posedge clk) begin : output_check
		expect_t	e;
		if (reset) begin
			held <= 1'b0;
		end else begin
			if (held) begin
				checks++;
				assert (valid_out && y_word == held_y && flags == held_f)
				else report_failure("output changed while the sink stalled");
			end
			held <= valid_out && !ready_in;
			held_y <= y_word;
			held_f <= flags;
			if (valid_out && ready_in) begin
				checks++;
				assert (exp_q.size() != 0)
				else report_failure("result appeared with no multiply outstanding");
				if (exp_q.size() != 0) begin
					e = exp_q.pop_front();
					assert (y_word == e.y) else report_mismatch("y_word", e.y, y_word);
					assert (flags == e.f)
					else report_mismatch("flags", 32'(e.f), 32'(flags));
					if (e.lat != 0) begin
						assert (cycle == e.cyc + e.lat + 1)
						else report_mismatch("latency", e.lat, cycle - e.cyc - 1);
					end
				end
			end
		end
	end

	function automatic fp_word_t random_normal();
		fp_word_t		w;
		logic	[31:0]	r;
		r = $random(seed);
		w.sgn = r[31];
		w.exp = 8'd80 + 8'(r[30:23] % 8'd96);	// Product stays in range.
		w.frac = r[22:0];
		return w;
	endfunction

	function automatic logic [63:0] special_pair(input int i);
		case (i)
			0: return {32'h7fc0_0000, 32'h3f80_0000};	// qNaN.
			1: return {32'h7f80_0001, 32'h4000_0000};	// sNaN.
			2: return {32'h7fa0_0000, 32'hffc0_0001};
			3: return {32'h0000_0000, 32'hff80_0000};	// Zero times infinity.
			4: return {32'h7f80_0000, 32'h8000_0000};
			5: return {32'h7f80_0000, 32'hc040_0000};
			6: return {32'hff80_0000, 32'hff80_0000};
			7: return {32'h8000_0000, 32'h40a0_0000};
			8: return {32'h0000_0001, 32'h4000_0000};	// Subnormal reads as zero.
			9: return {32'h4040_0000, 32'h807f_ffff};
			10: return {32'h7f80_0000, 32'h0000_0010};
			default: return {32'h7fc0_0000, 32'h0000_0000};
		endcase
	endfunction

	task automatic send_request(input fp_word_t a, input fp_word_t b, input fpu_op_t o,
			input fpu_rm_t r, input bit expect_out, input logic [3:0] lat);
		expect_t	e;
		fp_word_t	ey;
		fpu_flags_t	ef;
		@(posedge clk);
		valid_in <= 1'b1;
		a_word <= a;
		b_word <= b;
		op <= o;
		rm <= r;
		do
			@(posedge clk);
		while (!ready_out);
		valid_in <= 1'b0;
		if (expect_out) begin
			expected_product(a, b, r, ey, ef);
			e.y = ey;
			e.f = ef;
			e.cyc = cycle;
			e.lat = lat;
			exp_q.push_back(e);
		end
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic apply_flush(input int delay);
		repeat (delay) @(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		repeat (12) @(posedge clk);
	endtask

	task automatic end_test(input string name, input int mark);
		tests++;
		$display("test %-10s done, %0d errors", name, errors - mark);
	endtask

	initial begin
		fp_word_t	a;
		fp_word_t	b;
		fp_word_t	sa[N_STREAM];
		fp_word_t	sb[N_STREAM];
		fpu_rm_t	sr[N_STREAM];
		int			mark;
		reset = 1'b1;
		flush = 1'b0;
		valid_in = 1'b0;
		ready_in = 1'b1;
		a_word = '0;
		b_word = '0;
		op = FPU_OP_MUL;
		rm = RM_RNE;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		checks++;
		assert (!valid_out && ready_out) else report_failure("handshake not idle after reset");

		mark = errors;
		for (int m = 0; m < 5; m++) begin
			for (int i = 0; i < 9; i++) begin
				if (i == 0) begin
					a = 32'h3f80_0001;	// Exact tie with odd LSB.
					b = 32'h3fc0_0000;
				end else if (i == 1) begin
					a = 32'h3f80_0003;	// Exact tie with even LSB.
					b = 32'h3fc0_0000;
				end else begin
					a = random_normal();
					b = random_normal();
				end
				send_request(a, b, FPU_OP_MUL, fpu_rm_t'(m), 1'b1, 4'd7);
				wait_drained();
			end
		end
		end_test("normal", mark);

		mark = errors;
		for (int i = 0; i < N_SPECIAL; i++) begin
			{a, b} = special_pair(i);
			send_request(a, b, FPU_OP_MUL, fpu_rm_t'(i % 5), 1'b1, 4'd3);
			wait_drained();
		end
		end_test("special", mark);

		mark = errors;
		for (int m = 0; m < 5; m++) begin
			send_request(32'h7f00_0000, 32'h4000_0000, FPU_OP_MUL, fpu_rm_t'(m), 1'b1, 4'd7);
			wait_drained();
			send_request(32'hff00_0000, 32'h4000_0000, FPU_OP_MUL, fpu_rm_t'(m), 1'b1, 4'd7);
			wait_drained();
			a = {m[0], 31'h0080_0000};
			send_request(a, 32'h3f00_0000, FPU_OP_MUL, fpu_rm_t'(m), 1'b1, 4'd7);
			wait_drained();
		end
		end_test("range", mark);

		mark = errors;
		for (int i = 0; i < N_STREAM; i++) begin
			sa[i] = random_normal();
			sb[i] = (i % 5 == 4) ? fp_word_t'(32'h7f80_0000) : random_normal();
			sr[i] = fpu_rm_t'($unsigned($random(seed)) % 5);
		end
		stall_on <= 1'b1;
		for (int i = 0; i < N_STREAM; i++)
			send_request(sa[i], sb[i], FPU_OP_MUL, sr[i], 1'b1, 4'd0);
		wait_drained();
		stall_on <= 1'b0;
		@(posedge clk);
		ready_in <= 1'b1;
		end_test("stall", mark);

		mark = errors;
		send_request(random_normal(), random_normal(), FPU_OP_MUL, RM_RNE, 1'b0, 4'd0);
		apply_flush(3);
		send_request(32'h7f80_0000, 32'h4000_0000, FPU_OP_MUL, RM_RNE, 1'b0, 4'd0);
		apply_flush(1);
		send_request(random_normal(), random_normal(), FPU_OP_MUL, RM_RUP, 1'b0, 4'd0);
		@(posedge clk);
		reset <= 1'b1;
		repeat (16) @(posedge clk);
		checks++;
		assert (!valid_out) else report_failure("valid_out high during reset");
		reset <= 1'b0;
		send_request(random_normal(), random_normal(), FPU_OP_MUL, RM_RNE, 1'b1, 4'd7);
		wait_drained();
		end_test("flush", mark);

		mark = errors;
		send_request(random_normal(), random_normal(), FPU_OP_ADD, RM_RNE, 1'b0, 4'd0);
		send_request(random_normal(), random_normal(), FPU_OP_DIV, RM_RTZ, 1'b0, 4'd0);
		send_request(random_normal(), random_normal(), FPU_OP_SQRT, RM_RMM, 1'b0, 4'd0);
		repeat (12) @(posedge clk);
		send_request(random_normal(), random_normal(), FPU_OP_MUL, RM_RDN, 1'b1, 4'd7);
		wait_drained();
		end_test("other_op", mark);

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
